/* sys_io.f */
+incdir+include
logic/sys_io_pkg.sv
logic/sys_cfg_if.sv
logic/hps_cmd_decoder.sv
logic/sync_polarity_fix.sv
logic/csync_gen.sv
logic/video_sync_out.sv
logic/panel_io.sv
logic/sys_io_top.sv
test/tb_sys_io.sv

/* run_sim.sh */
#!/bin/sh
# Builds the sys_io testbench with Verilator and runs it.
# The log decides the result. A missing pass line also counts as failure.

rm -f sim.log
verilator --binary --timing --assert -j 0 -f sys_io.f --top-module tb_sys_io \
	&& ./obj_dir/Vtb_sys_io > sim.log 2>&1 \
	|| echo "build or run error" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

/* include/sys_io_tb_model.svh */
/*
 * Reference model for the host I/O testbench
 * Expected command registers, readback, LED byte and debounce limits
 */
`ifndef SYS_IO_TB_MODEL_SVH
`define SYS_IO_TB_MODEL_SVH

// Expected state after the last sampled bus word
sys_io_pkg::cmd_phase_t m_phase;
sys_io_pkg::cmd_code_t  m_cmd;
logic                   m_csync;
sys_io_pkg::led_byte_t  m_ovr;
sys_io_pkg::led_byte_t  m_state;
sys_io_pkg::vol_att_t   m_vol;
sys_io_pkg::io_word_t   m_dout;

// Samples that must agree before a button output moves
localparam int DEB_SAMPLES = 8;

function automatic void model_reset();
	m_phase = sys_io_pkg::PH_CMD;
	m_cmd   = '0;
	m_csync = 1'b0;
	m_ovr   = '0;
	m_state = '0;
	m_vol   = sys_io_pkg::VOL_ATT_RESET;
	m_dout  = '0;
endfunction

// Bus idle ends the transfer
function automatic void model_idle();
	m_phase = sys_io_pkg::PH_CMD;
	m_dout  = '0;
endfunction

function automatic void model_word(input sys_io_pkg::io_word_t w);
	if (m_phase == sys_io_pkg::PH_CMD) begin
		m_cmd   = w[7:0];
		m_phase = sys_io_pkg::PH_DATA;
		m_dout  = (w[7:0] == sys_io_pkg::CMD_STATUS) ? sys_io_pkg::STATUS_READY : '0;
	end else begin
		m_dout = '0;
		if (m_cmd == sys_io_pkg::CMD_CFG) begin
			m_csync = w[sys_io_pkg::CFG_CSYNC_BIT];
		end else if (m_cmd == sys_io_pkg::CMD_LED) begin
			m_ovr   = w[15:8];
			m_state = w[7:0];
		end else if (m_cmd == sys_io_pkg::CMD_VOL) begin
			m_vol = w[4:0];
		end
	end
endfunction

// Power LED only lights when forced on
function automatic logic power_lit(input logic [1:0] req);
	return req[1] && !req[0];
endfunction

function automatic logic disk_lit(input logic [1:0] req);
	return !req[0];
endfunction

function automatic sys_io_pkg::led_byte_t expected_led(input logic user,
		input logic [1:0] power, input logic [1:0] disk);
	sys_io_pkg::led_byte_t req;
	sys_io_pkg::led_byte_t led;
	req = '0;
	req[sys_io_pkg::LED_BIT_USER]  = user;
	req[sys_io_pkg::LED_BIT_DISK]  = disk_lit(disk);
	req[sys_io_pkg::LED_BIT_POWER] = power_lit(power);
	// Masked LEDs follow the host state and lit ones read low
	for (int i = 0; i < $bits(led); i++) begin
		led[i] = m_ovr[i] ? !m_state[i] : !req[i];
	end
	return led;
endfunction

// Worst case clocks from a stable input to the filtered output
function automatic int settle_clocks(input int div);
	return (DEB_SAMPLES + 2) * div + 2;
endfunction

// Longest glitch that still leaves the filter history mixed
function automatic int glitch_max(input int div);
	return (DEB_SAMPLES - 2) * div;
endfunction

`endif

/* test/tb_sys_io.sv */
/*
 * Testbench of the host I/O block
 * Random bus transfers, LED requests, button presses and sync timing,
 * compared against a reference model
 */
`timescale 1ns/1ps

module tb_sys_io;

	localparam int CLK_NS    = 100;
	localparam int DEB_DIV   = 4;
	localparam int SEED      = 8;
	localparam int N_XFER    = 40;
	localparam int MAX_DATA  = 4;
	localparam int N_LED     = 60;
	localparam int N_GLITCH  = 6;
	localparam int N_FRAMES  = 4;
	localparam int LINE_MAX  = 40;
	localparam int LINES_MAX = 14;

	// Clock budget of each test
	localparam int XFER_CLK  = N_XFER * (3 * MAX_DATA + 8) + 40;
	localparam int LED_CLK   = N_LED * 2 + (N_LED / 8 + 1) * 16;
	localparam int DEB_CLK   = 4 * N_GLITCH * 3 * 8 * DEB_DIV + 4 * 10 * DEB_DIV;
	localparam int SYNC_CLK  = (2 + 2 * N_FRAMES) * LINES_MAX * LINE_MAX + 40;
	localparam int WATCHDOG_CLK = 2 * (XFER_CLK + LED_CLK + DEB_CLK + SYNC_CLK) + 100;

	logic                  clk_sys;
	logic                  i_rst;
	logic                  i_io_uio;
	logic                  i_io_strobe;
	sys_io_pkg::io_word_t  i_io_din;
	sys_io_pkg::io_word_t  o_io_dout;
	logic                  i_hs;
	logic                  i_vs;
	logic                  o_hs;
	logic                  o_vs;
	logic                  i_btn_user_n;
	logic                  i_btn_osd_n;
	logic                  o_btn_user;
	logic                  o_btn_osd;
	logic                  i_led_user;
	logic [1:0]            i_led_power;
	logic [1:0]            i_led_disk;
	sys_io_pkg::led_byte_t o_led;
	logic                  o_led_power_n;
	logic                  o_led_hdd_n;
	logic                  o_led_user_n;
	sys_io_pkg::vol_att_t  o_vol_att;

	int   errors;
	int   checks;
	logic sync_check;
	logic hs_d1;
	logic hs_d2;
	logic vs_d1;
	logic vs_d2;

	`include "sys_io_tb_model.svh"

	sys_io_top #(
		.DEB_DIV (DEB_DIV)
	) i_dut (
		.clk_sys       (clk_sys),
		.i_rst         (i_rst),
		.i_io_uio      (i_io_uio),
		.i_io_strobe   (i_io_strobe),
		.i_io_din      (i_io_din),
		.o_io_dout     (o_io_dout),
		.i_hs          (i_hs),
		.i_vs          (i_vs),
		.o_hs          (o_hs),
		.o_vs          (o_vs),
		.i_btn_user_n  (i_btn_user_n),
		.i_btn_osd_n   (i_btn_osd_n),
		.o_btn_user    (o_btn_user),
		.o_btn_osd     (o_btn_osd),
		.i_led_user    (i_led_user),
		.i_led_power   (i_led_power),
		.i_led_disk    (i_led_disk),
		.o_led         (o_led),
		.o_led_power_n (o_led_power_n),
		.o_led_hdd_n   (o_led_hdd_n),
		.o_led_user_n  (o_led_user_n),
		.o_vol_att     (o_vol_att)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_NS / 2);
			clk_sys = ~clk_sys;
		end
	end

	//////////////////////////////
	// Checks

	task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic check_decoder();
		check_val("o_vol_att", 16'(o_vol_att), 16'(m_vol));
		check_val("o_io_dout", o_io_dout, m_dout);
		check_val("csync_en", 16'(i_dut.cfg.csync_en), 16'(m_csync));
	endtask

	task automatic check_led();
		check_val("o_led", 16'(o_led), 16'(expected_led(i_led_user, i_led_power, i_led_disk)));
	endtask

	task automatic check_regs();
		check_decoder();
		check_led();
	endtask

	//////////////////////////////
	// Host bus

	// One strobed word, then quiet cycles with noise on the data bus.
	// The LED byte is registered once more behind its setting
	task automatic send_word(input sys_io_pkg::io_word_t w);
		@(posedge clk_sys);
		i_io_strobe <= 1'b1;
		i_io_din    <= w;
		@(posedge clk_sys);
		i_io_strobe <= 1'b0;
		i_io_din    <= sys_io_pkg::io_word_t'($urandom);
		model_word(w);
		@(negedge clk_sys);
		check_decoder();
		@(negedge clk_sys);
		check_led();
	endtask

	task automatic begin_xfer(input sys_io_pkg::cmd_code_t code);
		@(posedge clk_sys);
		i_io_uio <= 1'b1;
		send_word({8'($urandom), code});
	endtask

	task automatic end_xfer();
		@(posedge clk_sys);
		i_io_uio <= 1'b0;
		model_idle();
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_regs();
	endtask

	// Known commands plus codes above 0x7f that the decoder ignores
	function automatic sys_io_pkg::cmd_code_t random_cmd();
		case ($urandom % 5)
			0: return sys_io_pkg::CMD_CFG;
			1: return sys_io_pkg::CMD_STATUS;
			2: return sys_io_pkg::CMD_LED;
			3: return sys_io_pkg::CMD_VOL;
			default: return 8'h80 | 8'($urandom % 128);
		endcase
	endfunction

	//////////////////////////////
	// Buttons

	task automatic drive_button(input bit osd, input logic pressed);
		if (osd) begin
			i_btn_osd_n <= !pressed;
		end else begin
			i_btn_user_n <= !pressed;
		end
	endtask

	function automatic logic button_out(input bit osd);
		return osd ? o_btn_osd : o_btn_user;
	endfunction

	task automatic wait_button(input bit osd, input logic level);
		int n;
		@(negedge clk_sys);
		n = 1;
		while (button_out(osd) != level && n < settle_clocks(DEB_DIV)) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		assert (button_out(osd) == level) else begin
			errors++;
			$display("%0t ns: %s button output did not settle to %0d in time",
				$time, osd ? "OSD" : "user", level);
		end
	endtask

	// Short change of the input that must not reach the output
	task automatic glitch_button(input bit osd, input logic held);
		int    len;
		string name;
		name = osd ? "o_btn_osd" : "o_btn_user";
		len  = $urandom_range(glitch_max(DEB_DIV), 1);
		@(posedge clk_sys);
		drive_button(osd, !held);
		for (int c = 1; c <= len + 2 * DEB_SAMPLES * DEB_DIV; c++) begin
			@(posedge clk_sys);
			if (c == len) begin
				drive_button(osd, held);
			end
			@(negedge clk_sys);
			check_val(name, 16'(button_out(osd)), 16'(held));
		end
	endtask

	//////////////////////////////
	// Video sync

	// Active low hsync and vsync, vsync pulse at the top of the frame
	task automatic run_frames(input int frames, input int h_len, input int h_pulse,
			input int lines, input int v_pulse);
		for (int f = 0; f < frames; f++) begin
			for (int l = 0; l < lines; l++) begin
				for (int c = 0; c < h_len; c++) begin
					@(posedge clk_sys);
					i_hs <= (c >= h_pulse);
					i_vs <= (l >= v_pulse);
				end
			end
		end
	endtask

	// Outputs against the inverted inputs of one and two clocks ago
	initial begin
		forever begin
			@(negedge clk_sys);
			if (sync_check) begin
				check_val("o_vs", 16'(o_vs), 16'(!vs_d1));
				if (!m_csync || vs_d2) begin
					check_val("o_hs", 16'(o_hs), 16'(!hs_d2));
				end
			end
			hs_d2 = hs_d1;
			hs_d1 = i_hs;
			vs_d2 = vs_d1;
			vs_d1 = i_vs;
		end
	end

	initial begin
		#(WATCHDOG_CLK * CLK_NS);
		$display("Watchdog expired after %0d clocks, the tests did not finish", WATCHDOG_CLK);
		$display("checks %0d errors %0d", checks, errors);
		$display("sim failed");
		$finish;
	end

	//////////////////////////////
	// Test sequence

	initial begin
		int rnd;
		int n;
		int h_len;
		int h_pulse;
		int lines;
		int v_pulse;
		rnd          = $urandom(SEED);
		errors       = 0;
		checks       = 0;
		sync_check   = 1'b0;
		hs_d1        = 1'b1;
		hs_d2        = 1'b1;
		vs_d1        = 1'b1;
		vs_d2        = 1'b1;
		i_rst        = 1'b1;
		i_io_uio     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_hs         = 1'b1;
		i_vs         = 1'b1;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		i_led_user   = 1'b0;
		i_led_power  = '0;
		i_led_disk   = '0;
		model_reset();
		repeat (2) @(posedge clk_sys);
		i_rst <= 1'b0;
		@(negedge clk_sys);
		check_val("o_led", 16'(o_led), 16'(sys_io_pkg::LED_ALL_OFF));
		check_val("o_vol_att", 16'(o_vol_att), 16'(sys_io_pkg::VOL_ATT_RESET));
		check_val("o_io_dout", o_io_dout, 16'h0000);
		check_val("o_btn_user", 16'(o_btn_user), 16'h0000);
		check_val("o_btn_osd", 16'(o_btn_osd), 16'h0000);

		// Random register writes
		for (int t = 0; t < N_XFER; t++) begin
			n = $urandom_range(MAX_DATA, 0);
			begin_xfer(random_cmd());
			for (int d = 0; d < n; d++) begin
				send_word(16'($urandom));
			end
			end_xfer();
		end

		// Readback holds until the next strobe and drops on an idle bus
		begin_xfer(sys_io_pkg::CMD_STATUS);
		repeat (3) begin
			@(negedge clk_sys);
			check_regs();
		end
		send_word(16'($urandom));
		end_xfer();
		begin_xfer(sys_io_pkg::CMD_STATUS);
		end_xfer();
		repeat (3) begin
			@(negedge clk_sys);
			check_regs();
		end

		// LED requests, overrides full random or masked off
		for (int t = 0; t < N_LED; t++) begin
			if (t % 8 == 0) begin
				begin_xfer(sys_io_pkg::CMD_LED);
				send_word((t % 16 == 0) ? 16'($urandom) : {8'h00, 8'($urandom)});
				end_xfer();
			end
			@(posedge clk_sys);
			i_led_user  <= 1'($urandom);
			i_led_power <= 2'($urandom);
			i_led_disk  <= 2'($urandom);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_regs();
			check_val("o_led_power_n", 16'(o_led_power_n), 16'(!power_lit(i_led_power)));
			check_val("o_led_hdd_n", 16'(o_led_hdd_n), 16'(!disk_lit(i_led_disk)));
			check_val("o_led_user_n", 16'(o_led_user_n), 16'(!i_led_user));
		end

		// Debounce, user button first
		for (int b = 0; b < 2; b++) begin
			@(posedge clk_sys);
			drive_button(b[0], 1'b1);
			wait_button(b[0], 1'b1);
			for (int g = 0; g < N_GLITCH; g++) begin
				glitch_button(b[0], 1'b1);
			end
			@(posedge clk_sys);
			drive_button(b[0], 1'b0);
			wait_button(b[0], 1'b0);
			for (int g = 0; g < N_GLITCH; g++) begin
				glitch_button(b[0], 1'b0);
			end
		end

		// Sync polarity, plain hsync then composite sync
		h_len   = $urandom_range(LINE_MAX, 20);
		h_pulse = $urandom_range(6, 3);
		lines   = $urandom_range(LINES_MAX, 8);
		v_pulse = $urandom_range(3, 2);
		begin_xfer(sys_io_pkg::CMD_CFG);
		send_word(16'h0000);
		end_xfer();
		run_frames(2, h_len, h_pulse, lines, v_pulse);
		sync_check = 1'b1;
		run_frames(N_FRAMES, h_len, h_pulse, lines, v_pulse);
		sync_check = 1'b0;
		begin_xfer(sys_io_pkg::CMD_CFG);
		send_word(16'h0008);
		end_xfer();
		sync_check = 1'b1;
		run_frames(N_FRAMES, h_len, h_pulse, lines, v_pulse);
		sync_check = 1'b0;

		@(negedge clk_sys);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* logic/sys_io_top.sv */
/*
 * Host I/O block top level
 * Command decoder, sync output path and front panel logic on one clock
 */
`timescale 1ns/1ps

module sys_io_top #(
	parameter int DEB_DIV    = 100000,
	parameter int SYNC_CNT_W = 16
) (
	input  logic                  clk_sys,
	input  logic                  i_rst,
	// Host word bus
	input  logic                  i_io_uio,
	input  logic                  i_io_strobe,
	input  sys_io_pkg::io_word_t  i_io_din,
	output sys_io_pkg::io_word_t  o_io_dout,
	// Video sync
	input  logic                  i_hs,
	input  logic                  i_vs,
	output logic                  o_hs,
	output logic                  o_vs,
	// Buttons
	input  logic                  i_btn_user_n,
	input  logic                  i_btn_osd_n,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	// Core LED requests
	input  logic                  i_led_user,
	input  logic [1:0]            i_led_power,
	input  logic [1:0]            i_led_disk,
	// LED outputs
	output sys_io_pkg::led_byte_t o_led,
	output logic                  o_led_power_n,
	output logic                  o_led_hdd_n,
	output logic                  o_led_user_n,
	output sys_io_pkg::vol_att_t  o_vol_att
);

	sys_cfg_if cfg ();

	// Attenuation goes to an external audio block
	assign o_vol_att = cfg.vol_att;

	hps_cmd_decoder i_decoder (
		.clk_sys     (clk_sys),
		.i_rst       (i_rst),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_io_dout   (o_io_dout),
		.cfg         (cfg.decoder)
	);

	video_sync_out #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) i_video (
		.clk_sys (clk_sys),
		.i_rst   (i_rst),
		.i_hs    (i_hs),
		.i_vs    (i_vs),
		.o_hs    (o_hs),
		.o_vs    (o_vs),
		.cfg     (cfg.video)
	);

	panel_io #(
		.DEB_DIV (DEB_DIV)
	) i_panel (
		.clk_sys       (clk_sys),
		.i_rst         (i_rst),
		.i_btn_user_n  (i_btn_user_n),
		.i_btn_osd_n   (i_btn_osd_n),
		.i_led_user    (i_led_user),
		.i_led_power   (i_led_power),
		.i_led_disk    (i_led_disk),
		.o_btn_user    (o_btn_user),
		.o_btn_osd     (o_btn_osd),
		.o_led         (o_led),
		.o_led_power_n (o_led_power_n),
		.o_led_hdd_n   (o_led_hdd_n),
		.o_led_user_n  (o_led_user_n),
		.cfg           (cfg.panel)
	);

endmodule

/* logic/panel_io.sv */
/*
 * Front panel buttons and LEDs
 * Debounces the user and OSD buttons on a slow tick and builds the LED
 * outputs from core requests or the host override
 */
`timescale 1ns/1ps

module panel_io #(
	parameter int DEB_DIV = 100000
) (
	input  logic                  clk_sys,
	input  logic                  i_rst,
	input  logic                  i_btn_user_n,
	input  logic                  i_btn_osd_n,
	input  logic                  i_led_user,
	input  logic [1:0]            i_led_power,
	input  logic [1:0]            i_led_disk,
	output logic                  o_btn_user,
	output logic                  o_btn_osd,
	output sys_io_pkg::led_byte_t o_led,
	output logic                  o_led_power_n,
	output logic                  o_led_hdd_n,
	output logic                  o_led_user_n,
	sys_cfg_if.panel              cfg
);

	localparam int DIV_W = (DEB_DIV > 1) ? $clog2(DEB_DIV) : 1;

	logic [DIV_W-1:0]      div_cnt;
	logic                  tick;
	logic [1:0]            btn_raw;
	logic [1:0][7:0]       btn_hist;
	logic [1:0]            btn_q;
	logic                  lit_p;
	logic                  lit_d;
	logic                  lit_u;
	sys_io_pkg::led_byte_t req_led;
	sys_io_pkg::led_byte_t led_next;

	//////////////////////////////
	// Debounce

	assign tick = (div_cnt == DIV_W'(DEB_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (i_rst || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Index 0 is user, 1 is OSD
	assign btn_raw = ~{i_btn_osd_n, i_btn_user_n};

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			btn_hist <= '0;
			btn_q    <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				btn_hist[i] <= {btn_hist[i][6:0], btn_raw[i]};
				if (&btn_hist[i]) begin
					btn_q[i] <= 1'b1;
				end else if (btn_hist[i] == '0) begin
					btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	//////////////////////////////
	// LEDs

	assign lit_p = i_led_power[1] ? ~i_led_power[0] : 1'b0;
	// Forced and automatic disk modes give the same level
	assign lit_d = ~i_led_disk[0];
	assign lit_u = i_led_user;

	always_comb begin
		req_led = '0;
		req_led[sys_io_pkg::LED_BIT_USER]  = lit_u;
		req_led[sys_io_pkg::LED_BIT_DISK]  = lit_d;
		req_led[sys_io_pkg::LED_BIT_POWER] = lit_p;
		// Board LEDs are active low
		led_next = ~((cfg.led_overtake & cfg.led_state) | (~cfg.led_overtake & req_led));
	end

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			o_led         <= sys_io_pkg::LED_ALL_OFF;
			o_led_power_n <= 1'b1;
			o_led_hdd_n   <= 1'b1;
			o_led_user_n  <= 1'b1;
		end else begin
			o_led         <= led_next;
			o_led_power_n <= ~lit_p;
			o_led_hdd_n   <= ~lit_d;
			o_led_user_n  <= ~lit_u;
		end
	end

	// Output moves on a tick, to the level of its last eight samples
	a_btn_on_tick: assert property (
		@(posedge clk_sys) disable iff (i_rst)
		$changed(btn_q) |-> $past(tick)
			&& (!$changed(btn_q[0]) || $past(btn_hist[0]) == {8{btn_q[0]}})
			&& (!$changed(btn_q[1]) || $past(btn_hist[1]) == {8{btn_q[1]}})
	) else $error("button output changed without a tick and a uniform history");

endmodule

/* logic/video_sync_out.sv */
/*
 * Video sync output path
 * Normalizes hsync and vsync to active high and selects plain or composite sync
 */
`timescale 1ns/1ps

module video_sync_out #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic     clk_sys,
	input  logic     i_rst,
	input  logic     i_hs,
	input  logic     i_vs,
	output logic     o_hs,
	output logic     o_vs,
	sys_cfg_if.video cfg
);

	logic hs_fix;
	logic vs_fix;
	logic csync;
	logic hs_d;

	sync_polarity_fix #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) i_fix_h (
		.clk_sys (clk_sys),
		.i_rst   (i_rst),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) i_fix_v (
		.clk_sys (clk_sys),
		.i_rst   (i_rst),
		.i_sync  (i_vs),
		.o_sync  (vs_fix)
	);

	csync_gen #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) i_csync (
		.clk_sys (clk_sys),
		.i_rst   (i_rst),
		.i_hs    (hs_fix),
		.i_vs    (vs_fix),
		.o_csync (csync)
	);

	// Plain hsync delayed to line up with csync
	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			hs_d <= 1'b0;
			o_hs <= 1'b0;
			o_vs <= 1'b0;
		end else begin
			hs_d <= hs_fix;
			o_hs <= cfg.csync_en ? csync : hs_d;
			o_vs <= vs_fix;
		end
	end

endmodule

/* logic/csync_gen.sv */
/*
 * Composite sync generator
 * Passes hsync outside vsync. During vsync the hsync pulse is moved one
 * hsync width ahead of the line start and the result is inverted
 */
`timescale 1ns/1ps

module csync_gen #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic i_rst,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic                  prev_hs;
	logic                  hs_edge;
	logic                  hs_rise;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic                  csync_hs;
	logic                  hs_next;

	assign hs_edge = prev_hs ^ i_hs;
	assign hs_rise = hs_edge & i_hs;

	// Shifted hsync pattern
	always_comb begin
		if (!i_vs) begin
			hs_next = i_hs;
		end else if (h_cnt == line_len) begin
			hs_next = 1'b1;
		end else if (hs_rise) begin
			hs_next = 1'b0;
		end else begin
			hs_next = csync_hs;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			prev_hs  <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			csync_hs <= 1'b0;
			o_csync  <= 1'b0;
		end else begin
			prev_hs <= i_hs;
			h_cnt   <= hs_edge ? '0 : h_cnt + 1'b1;
			// Low time minus pulse width marks the early pulse start
			if (hs_rise) begin
				line_len <= h_cnt - hs_len;
			end
			if (hs_edge && !i_hs) begin
				hs_len <= h_cnt;
			end
			csync_hs <= hs_next;
			o_csync  <= hs_next ^ i_vs;
		end
	end

endmodule

/* logic/sync_polarity_fix.sv */
/*
 * Sync polarity normalizer
 * Compares high and low widths of a sync signal and inverts it if active low
 */
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic i_rst,
	input  logic i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;
	logic                  pol;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Width counter restarts on each edge and saturates on a dead input
			if (s1 != s2) begin
				cnt <= '0;
			end else if (~&cnt) begin
				cnt <= cnt + 1'b1;
			end
			if (s1 && !s2) begin
				lo_len <= cnt;
			end
			if (!s1 && s2) begin
				hi_len <= cnt;
			end
			// Wider side is the inactive level
			pol <= (hi_len > lo_len);
		end
	end

	a_pol_after_edge: assert property (
		@(posedge clk_sys) disable iff (i_rst)
		$changed(pol) |-> $past(s1 != s2, 2)
	) else $error("sync polarity changed without an input edge");

endmodule

/* logic/hps_cmd_decoder.sv */
/*
 * Host command decoder
 * First strobed word of a transfer selects the command, later words are data.
 * Holds the csync, LED override and volume settings and the status readback
 */
`timescale 1ns/1ps

module hps_cmd_decoder (
	input  logic                 clk_sys,
	input  logic                 i_rst,
	input  logic                 i_io_uio,
	input  logic                 i_io_strobe,
	input  sys_io_pkg::io_word_t i_io_din,
	output sys_io_pkg::io_word_t o_io_dout,
	sys_cfg_if.decoder           cfg
);

	sys_io_pkg::cmd_phase_t phase;
	sys_io_pkg::cmd_code_t  cmd;
	sys_io_pkg::cmd_code_t  din_code;
	logic                   cmd_stb;
	logic                   data_stb;

	assign din_code = i_io_din[7:0];
	assign cmd_stb  = i_io_uio && i_io_strobe && (phase == sys_io_pkg::PH_CMD);
	assign data_stb = i_io_uio && i_io_strobe && (phase == sys_io_pkg::PH_DATA);

	//////////////////////////////
	// Transfer phase and readback

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			phase     <= sys_io_pkg::PH_CMD;
			o_io_dout <= '0;
		end else if (!i_io_uio) begin
			// Idle bus, next strobe is a command again
			phase     <= sys_io_pkg::PH_CMD;
			o_io_dout <= '0;
		end else if (i_io_strobe) begin
			o_io_dout <= '0;
			if (phase == sys_io_pkg::PH_CMD) begin
				phase <= sys_io_pkg::PH_DATA;
				if (din_code == sys_io_pkg::CMD_STATUS) begin
					o_io_dout <= sys_io_pkg::STATUS_READY;
				end
			end
		end
	end

	// Command byte, only read in the data phase
	always_ff @(posedge clk_sys) begin
		if (cmd_stb) begin
			cmd <= din_code;
		end
	end

	//////////////////////////////
	// Setting registers

	always_ff @(posedge clk_sys) begin
		if (i_rst) begin
			cfg.csync_en     <= 1'b0;
			cfg.led_overtake <= '0;
			cfg.led_state    <= '0;
			cfg.vol_att      <= sys_io_pkg::VOL_ATT_RESET;
		end else if (data_stb) begin
			case (cmd)
				sys_io_pkg::CMD_CFG: begin
					cfg.csync_en <= i_io_din[sys_io_pkg::CFG_CSYNC_BIT];
				end
				sys_io_pkg::CMD_LED: begin
					// Mask in the high byte, state in the low byte
					cfg.led_overtake <= i_io_din[15:8];
					cfg.led_state    <= i_io_din[7:0];
				end
				sys_io_pkg::CMD_VOL: begin
					cfg.vol_att <= i_io_din[4:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Readback only inside an open status transfer
	a_dout_status: assert property (
		@(posedge clk_sys) disable iff (i_rst)
		(o_io_dout != '0) |->
			(phase == sys_io_pkg::PH_DATA) && (cmd == sys_io_pkg::CMD_STATUS)
	) else $error("readback nonzero outside a status transfer");

endmodule

/* logic/sys_cfg_if.sv */
/*
 * Decoded host settings
 * Carries register values from the command decoder to the video and panel logic
 */
`timescale 1ns/1ps

interface sys_cfg_if;

	logic                  csync_en;
	sys_io_pkg::led_byte_t led_overtake;
	sys_io_pkg::led_byte_t led_state;
	sys_io_pkg::vol_att_t  vol_att;

	modport decoder (
		output csync_en,
		output led_overtake,
		output led_state,
		output vol_att
	);

	modport video (
		input csync_en
	);

	modport panel (
		input led_overtake,
		input led_state
	);

endinterface

/* logic/sys_io_pkg.sv */
/*
 * Shared definitions of the host I/O block
 * Bus word types, host command codes, LED bit positions and reset values
 */
package sys_io_pkg;

	//////////////////////////////
	// Types

	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  led_byte_t;
	typedef logic [4:0]  vol_att_t;
	typedef logic [7:0]  cmd_code_t;

	// Command word or data words of a transfer
	typedef enum logic {
		PH_CMD,
		PH_DATA
	} cmd_phase_t;

	//////////////////////////////
	// Host commands

	localparam cmd_code_t CMD_CFG    = 8'h01;
	localparam cmd_code_t CMD_STATUS = 8'h20;
	localparam cmd_code_t CMD_LED    = 8'h25;
	localparam cmd_code_t CMD_VOL    = 8'h26;

	// Composite sync enable inside the configuration word
	localparam int CFG_CSYNC_BIT = 3;

	localparam io_word_t STATUS_READY = 16'd3;

	// Main board LED byte layout
	localparam int LED_BIT_USER  = 0;
	localparam int LED_BIT_DISK  = 2;
	localparam int LED_BIT_POWER = 4;

	// Values after reset
	localparam vol_att_t  VOL_ATT_RESET = '1;
	localparam led_byte_t LED_ALL_OFF   = '1;

endpackage
